// ==== source/rtc_macros.svh ====
`ifndef RTC_MACROS_SVH
`define RTC_MACROS_SVH

////////////////////
// tick generator
////////////////////

// phase accumulator width, speed register is the low 32 bits of the increment
`define RTC_ACC_W 40

// sub-second counter width, one second is 2**RTC_SUB_W carries
`define RTC_SUB_W 8

// speed at reset, 2**48 / 100e6 for a one second period at 100 MHz
`define RTC_CKSPEED_RST 32'd2814750

////////////////////
// hack capture
////////////////////

// default number of buffered hack stamps
`define RTC_HACK_DEPTH 4

`endif

// ==== source/rtc_pkg.sv ====
`default_nettype none

`include "rtc_macros.svh"

package rtc_pkg;

	// hh:mm:ss in packed BCD, hours only need two bits of tens
	typedef struct packed {
		logic [5:0] hours;
		logic [7:0] minutes;
		logic [7:0] seconds;
	} bcd_time_t;

	// countdown state as seen on the bus
	typedef struct packed {
		logic        expired;
		logic        running;
		logic [23:0] remaining;
	} timer_t;

	// stopwatch readback word
	typedef struct packed {
		logic [23:0] hms;
		logic [6:0]  sub;
		logic        running;
	} stopwatch_t;

	// time of day plus sub-second count at the hack edge
	typedef struct packed {
		bcd_time_t             tod;
		logic [`RTC_SUB_W-1:0] sub;
	} hack_stamp_t;

	// register map
	typedef enum logic [2:0] {
		RTC_ADDR_CLOCK     = 3'd0,
		RTC_ADDR_TIMER     = 3'd1,
		RTC_ADDR_STOPWATCH = 3'd2,
		RTC_ADDR_ALARM     = 3'd3,
		RTC_ADDR_SPEED     = 3'd4,
		RTC_ADDR_HACK      = 3'd5
	} rtc_addr_e;

endpackage

`default_nettype wire

// ==== source/rtc_tick_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rtc_macros.svh"

module rtc_tick_gen
(
	input  wire                   i_clk,
	input  wire                   i_arst_n,
	input  wire                   i_speed_we,
	input  wire  [31:0]           i_speed,
	output logic [31:0]           o_speed,
	output logic                  o_carry,
	output logic [`RTC_SUB_W-1:0] o_sub,
	output logic                  o_pps
);

	logic [31:0]           speed;
	logic [`RTC_ACC_W-1:0] acc;
	logic [`RTC_ACC_W:0]   acc_sum;
	logic                  carry;
	logic [`RTC_SUB_W-1:0] sub;

	// speed register, increment per system clock
	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
			speed <= `RTC_CKSPEED_RST;
		else if (i_speed_we)
			speed <= i_speed;
	end

	// zero extend the speed into the accumulator width plus carry
	assign acc_sum = {1'b0, acc} + {{(`RTC_ACC_W - 31){1'b0}}, speed};

	// fractional phase accumulator
	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			acc   <= '0;
			carry <= 1'b0;
		end
		else
		begin
			acc   <= acc_sum[`RTC_ACC_W-1:0];
			carry <= acc_sum[`RTC_ACC_W];
		end
	end

	// sub-second counter, one step per carry
	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
			sub <= '0;
		else if (carry)
			sub <= sub + 1'b1;
	end

	// pps is the carry that wraps the sub-second counter
	assign o_pps   = carry && (sub == '1);
	assign o_carry = carry;
	assign o_sub   = sub;
	assign o_speed = speed;

endmodule

`default_nettype wire

// ==== source/rtc_time_of_day.sv ====
`timescale 1ns/10ps
`default_nettype none

module rtc_time_of_day
(
	input  wire                i_clk,
	input  wire                i_arst_n,
	input  wire                i_pps,
	input  wire                i_set_we,
	input  wire                i_alarm_we,
	input  wire  [31:0]        i_data,
	output rtc_pkg::bcd_time_t o_time,
	output rtc_pkg::bcd_time_t o_alarm_time,
	output logic               o_alarm_enabled,
	output logic               o_alarm_tripped,
	output logic               o_alarm_pulse
);

	rtc_pkg::bcd_time_t tod;
	rtc_pkg::bcd_time_t tod_next;
	rtc_pkg::bcd_time_t last_tod;
	rtc_pkg::bcd_time_t alarm_time;
	logic               alarm_enabled;
	logic               alarm_tripped;
	logic               alarm_pulse;
	logic               alarm_hit;

	// two digit BCD step with rollover at 59
	function automatic logic [7:0] bcd60_inc(input logic [7:0] v);
		logic [7:0] r;
		if (v == 8'h59)
			r = 8'h00;
		else if (v[3:0] == 4'h9)
			r = {v[7:4] + 4'h1, 4'h0};
		else
			r = {v[7:4], v[3:0] + 4'h1};
		return r;
	endfunction

	// hours step with rollover at 23
	function automatic logic [5:0] bcd24_inc(input logic [5:0] v);
		logic [5:0] r;
		if (v == 6'h23)
			r = 6'h00;
		else if (v[3:0] == 4'h9)
			r = {v[5:4] + 2'h1, 4'h0};
		else
			r = {v[5:4], v[3:0] + 4'h1};
		return r;
	endfunction

	// an all ones field leaves the old value in place
	function automatic rtc_pkg::bcd_time_t masked_time(
		input rtc_pkg::bcd_time_t old,
		input logic [31:0]        d
	);
		rtc_pkg::bcd_time_t r;
		r = old;
		if (d[21:16] != 6'h3f)
			r.hours = d[21:16];
		if (d[15:8] != 8'hff)
			r.minutes = d[15:8];
		if (d[7:0] != 8'hff)
			r.seconds = d[7:0];
		return r;
	endfunction

	////////////////////
	// time of day
	////////////////////

	// ripple the carry through seconds, minutes and hours
	always_comb
	begin
		tod_next         = tod;
		tod_next.seconds = bcd60_inc(tod.seconds);
		if (tod.seconds == 8'h59)
		begin
			tod_next.minutes = bcd60_inc(tod.minutes);
			if (tod.minutes == 8'h59)
				tod_next.hours = bcd24_inc(tod.hours);
		end
	end

	// a bus set wins over the pps step
	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			tod      <= '0;
			last_tod <= '0;
		end
		else
		begin
			if (i_set_we)
				tod <= masked_time(tod, i_data);
			else if (i_pps)
				tod <= tod_next;
			// previous value, for edge detect on the alarm compare
			last_tod <= tod;
		end
	end

	////////////////////
	// daily alarm
	////////////////////

	// hit only on the first cycle the time matches
	assign alarm_hit = alarm_enabled && (tod == alarm_time) && (last_tod != alarm_time);

	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			alarm_time    <= '0;
			alarm_enabled <= 1'b0;
			alarm_tripped <= 1'b0;
			alarm_pulse   <= 1'b0;
		end
		else
		begin
			if (i_alarm_we)
			begin
				alarm_time    <= masked_time(alarm_time, i_data);
				alarm_enabled <= i_data[24];
				// bit 25 acknowledges, disabling also clears
				if (i_data[25] || !i_data[24])
					alarm_tripped <= 1'b0;
			end
			if (alarm_hit)
				alarm_tripped <= 1'b1;
			alarm_pulse <= alarm_hit;
		end
	end

	assign o_time          = tod;
	assign o_alarm_time    = alarm_time;
	assign o_alarm_enabled = alarm_enabled;
	assign o_alarm_tripped = alarm_tripped;
	assign o_alarm_pulse   = alarm_pulse;

endmodule

`default_nettype wire

// ==== source/rtc_countdown.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rtc_macros.svh"

module rtc_countdown
(
	input  wire             i_clk,
	input  wire             i_arst_n,
	input  wire             i_carry,
	input  wire             i_we,
	input  wire  [31:0]     i_data,
	output rtc_pkg::timer_t o_timer,
	output logic            o_expire_pulse
);

	rtc_pkg::timer_t       timer;
	logic [23:0]           start_val;
	logic [`RTC_SUB_W-1:0] sub;
	logic                  sec_tick;
	logic                  expire_pulse;

	// BCD hh:mm:ss minus one, only called with a nonzero value
	function automatic logic [23:0] hms_dec(input logic [23:0] v);
		logic [23:0] r;
		logic        borrow;
		logic [3:0]  lim;
		r      = v;
		borrow = 1'b1;
		for (int i = 0; i < 6; i++)
		begin
			// tens of seconds and minutes run 0 to 5
			lim = ((i == 1) || (i == 3)) ? 4'h5 : 4'h9;
			if (borrow)
			begin
				if (r[4*i +: 4] == 4'h0)
					r[4*i +: 4] = lim;
				else
				begin
					r[4*i +: 4] = r[4*i +: 4] - 4'h1;
					borrow      = 1'b0;
				end
			end
		end
		return r;
	endfunction

	// one second of private carries while running
	assign sec_tick = timer.running && i_carry && (sub == '1);

	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			timer        <= '0;
			start_val    <= '0;
			sub          <= '0;
			expire_pulse <= 1'b0;
		end
		else
		begin
			expire_pulse <= 1'b0;
			if (i_we && timer.running)
			begin
				// while running a write can only stop the timer
				timer.running <= i_data[24];
			end
			else if (i_we)
			begin
				timer.running <= i_data[24];
				timer.expired <= 1'b0;
				if (i_data[23:0] != 24'h0)
				begin
					timer.remaining <= i_data[23:0];
					start_val       <= i_data[23:0];
					sub             <= '0;
				end
				else if (timer.remaining == 24'h0)
				begin
					// zero on zero restores the last start value
					timer.remaining <= start_val;
					sub             <= '0;
				end
			end
			else if (timer.running)
			begin
				if (i_carry)
					sub <= sub + 1'b1;
				if (timer.remaining == 24'h0)
				begin
					// reached zero, stop and flag once
					timer.expired <= 1'b1;
					timer.running <= 1'b0;
					expire_pulse  <= 1'b1;
				end
				else if (sec_tick)
					timer.remaining <= hms_dec(timer.remaining);
			end
		end
	end

	assign o_timer        = timer;
	assign o_expire_pulse = expire_pulse;

endmodule

`default_nettype wire

// ==== source/rtc_stopwatch.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rtc_macros.svh"

module rtc_stopwatch
(
	input  wire                 i_clk,
	input  wire                 i_arst_n,
	input  wire                 i_carry,
	input  wire                 i_we,
	input  wire  [31:0]         i_data,
	output rtc_pkg::stopwatch_t o_watch
);

	logic [23:0]           hms;
	logic [`RTC_SUB_W-1:0] sub;
	logic                  running;
	logic                  sec_tick;

	// BCD hh:mm:ss plus one, hour tens sticks at 9
	function automatic logic [23:0] hms_inc(input logic [23:0] v);
		logic [23:0] r;
		logic        carry;
		logic [3:0]  lim;
		r     = v;
		carry = 1'b1;
		for (int i = 0; i < 6; i++)
		begin
			lim = ((i == 1) || (i == 3)) ? 4'h5 : 4'h9;
			if (carry)
			begin
				if (r[4*i +: 4] >= lim)
				begin
					// top digit saturates instead of wrapping
					if (i < 5)
						r[4*i +: 4] = 4'h0;
				end
				else
				begin
					r[4*i +: 4] = r[4*i +: 4] + 4'h1;
					carry       = 1'b0;
				end
			end
		end
		return r;
	endfunction

	assign sec_tick = running && i_carry && (sub == '1);

	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			hms     <= '0;
			sub     <= '0;
			running <= 1'b0;
		end
		else
		begin
			if (running && i_carry)
				sub <= sub + 1'b1;
			if (sec_tick)
				hms <= hms_inc(hms);
			if (i_we)
			begin
				running <= i_data[0];
				// clear only if stopped before or after this write
				if (i_data[1] && (!running || !i_data[0]))
				begin
					hms <= '0;
					sub <= '0;
				end
			end
		end
	end

	// sub-second shown at 7 bit resolution, lsb is the run flag
	assign o_watch = '{hms: hms, sub: sub[`RTC_SUB_W-1 -: 7], running: running};

endmodule

`default_nettype wire

// ==== source/rtc_hack_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rtc_macros.svh"

module rtc_hack_fifo
#(
	parameter int DEPTH = `RTC_HACK_DEPTH
)
(
	input  wire                  i_clk,
	input  wire                  i_arst_n,
	input  wire                  i_push,
	input  wire rtc_pkg::hack_stamp_t i_stamp,
	input  wire                  i_pop,
	output rtc_pkg::hack_stamp_t o_stamp,
	output logic                 o_valid,
	output logic                 o_overflow
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	rtc_pkg::hack_stamp_t mem [DEPTH];
	logic [AW-1:0]        wr_ptr;
	logic [AW-1:0]        rd_ptr;
	logic [CW-1:0]        count;
	logic                 full;
	logic                 do_push;
	logic                 do_pop;
	logic                 overflow;

	// circular pointer step
	function automatic logic [AW-1:0] ptr_next(input logic [AW-1:0] p);
		return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign full    = (count == CW'(DEPTH));
	assign do_push = i_push && !full;
	assign do_pop  = i_pop && (count != '0);

	// stamp storage
	always_ff @(posedge i_clk)
	begin
		if (do_push)
			mem[wr_ptr] <= i_stamp;
	end

	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			overflow <= 1'b0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= ptr_next(wr_ptr);
			if (do_pop)
				rd_ptr <= ptr_next(rd_ptr);
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
			// a lost stamp outranks the clearing read
			if (i_push && full)
				overflow <= 1'b1;
			else if (i_pop)
				overflow <= 1'b0;
		end
	end

	assign o_stamp    = mem[rd_ptr];
	assign o_valid    = (count != '0);
	assign o_overflow = overflow;

endmodule

`default_nettype wire

// ==== source/rtc_core.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rtc_macros.svh"

module rtc_core
(
	input  wire                   i_clk,
	input  wire                   i_arst_n,
	input  wire                   i_stb,
	input  wire                   i_we,
	input  wire rtc_pkg::rtc_addr_e i_addr,
	input  wire  [31:0]           i_data,
	input  wire                   i_hack,
	output logic [31:0]           o_data,
	output logic                  o_interrupt
);

	logic                  wr_stb;
	logic                  clock_we;
	logic                  timer_we;
	logic                  watch_we;
	logic                  alarm_we;
	logic                  speed_we;
	logic                  hack_pop;

	logic [31:0]           speed;
	logic                  carry;
	logic [`RTC_SUB_W-1:0] sub;
	logic                  pps;

	rtc_pkg::bcd_time_t    cur_time;
	rtc_pkg::bcd_time_t    alarm_time;
	logic                  alarm_enabled;
	logic                  alarm_tripped;
	logic                  alarm_pulse;
	rtc_pkg::timer_t       timer;
	logic                  expire_pulse;
	rtc_pkg::stopwatch_t   watch;

	rtc_pkg::hack_stamp_t  hack_stamp;
	rtc_pkg::hack_stamp_t  hack_head;
	logic                  hack_valid;
	logic                  hack_overflow;

	////////////////////
	// address decode
	////////////////////

	assign wr_stb   = i_stb && i_we;
	assign clock_we = wr_stb && (i_addr == rtc_pkg::RTC_ADDR_CLOCK);
	assign timer_we = wr_stb && (i_addr == rtc_pkg::RTC_ADDR_TIMER);
	assign watch_we = wr_stb && (i_addr == rtc_pkg::RTC_ADDR_STOPWATCH);
	assign alarm_we = wr_stb && (i_addr == rtc_pkg::RTC_ADDR_ALARM);
	assign speed_we = wr_stb && (i_addr == rtc_pkg::RTC_ADDR_SPEED);
	// a plain read of the hack register consumes the head
	assign hack_pop = i_stb && !i_we && (i_addr == rtc_pkg::RTC_ADDR_HACK);

	////////////////////
	// timekeeping blocks
	////////////////////

	rtc_tick_gen u_tick_gen (
		.i_clk      (i_clk),
		.i_arst_n   (i_arst_n),
		.i_speed_we (speed_we),
		.i_speed    (i_data),
		.o_speed    (speed),
		.o_carry    (carry),
		.o_sub      (sub),
		.o_pps      (pps)
	);

	rtc_time_of_day u_time_of_day (
		.i_clk           (i_clk),
		.i_arst_n        (i_arst_n),
		.i_pps           (pps),
		.i_set_we        (clock_we),
		.i_alarm_we      (alarm_we),
		.i_data          (i_data),
		.o_time          (cur_time),
		.o_alarm_time    (alarm_time),
		.o_alarm_enabled (alarm_enabled),
		.o_alarm_tripped (alarm_tripped),
		.o_alarm_pulse   (alarm_pulse)
	);

	rtc_countdown u_countdown (
		.i_clk          (i_clk),
		.i_arst_n       (i_arst_n),
		.i_carry        (carry),
		.i_we           (timer_we),
		.i_data         (i_data),
		.o_timer        (timer),
		.o_expire_pulse (expire_pulse)
	);

	rtc_stopwatch u_stopwatch (
		.i_clk    (i_clk),
		.i_arst_n (i_arst_n),
		.i_carry  (carry),
		.i_we     (watch_we),
		.i_data   (i_data),
		.o_watch  (watch)
	);

	// stamp is the live time and sub-second count
	assign hack_stamp = '{tod: cur_time, sub: sub};

	rtc_hack_fifo #(
		.DEPTH (`RTC_HACK_DEPTH)
	) u_hack_fifo (
		.i_clk      (i_clk),
		.i_arst_n   (i_arst_n),
		.i_push     (i_hack),
		.i_stamp    (hack_stamp),
		.i_pop      (hack_pop),
		.o_stamp    (hack_head),
		.o_valid    (hack_valid),
		.o_overflow (hack_overflow)
	);

	////////////////////
	// readback
	////////////////////

	// registered every cycle, strobe or not
	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
			o_data <= '0;
		else
		begin
			case (i_addr)
				rtc_pkg::RTC_ADDR_CLOCK:     o_data <= {10'h0, cur_time};
				rtc_pkg::RTC_ADDR_TIMER:     o_data <= {6'h0, timer};
				rtc_pkg::RTC_ADDR_STOPWATCH: o_data <= watch;
				rtc_pkg::RTC_ADDR_ALARM:
					o_data <= {6'h0, alarm_tripped, alarm_enabled, 2'b00, alarm_time};
				rtc_pkg::RTC_ADDR_SPEED:     o_data <= speed;
				// empty slots read back as zero stamp
				rtc_pkg::RTC_ADDR_HACK:
					o_data <= {hack_valid, hack_overflow, hack_valid ? hack_head : 30'h0};
				default:                     o_data <= '0;
			endcase
		end
	end

	// both sources are single cycle pulses
	assign o_interrupt = expire_pulse || alarm_pulse;

endmodule

`default_nettype wire

// ==== dv/rtc_clk_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module rtc_clk_gen
#(
	parameter int HALF_NS    = 5,
	parameter int RST_CYCLES = 5
)
(
	output logic o_clk,
	output logic o_arst_n
);

	// free running 10 ns clock
	initial
	begin
		o_clk = 1'b0;
		forever
			#(HALF_NS) o_clk = ~o_clk;
	end

	// reset low for the first cycles, released just after an edge
	initial
	begin
		o_arst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge o_clk);
		#1;
		o_arst_n = 1'b1;
	end

endmodule

`default_nettype wire

// ==== dv/rtc_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rtc_macros.svh"

module rtc_tb;

	// one second at full speed is 65536 clocks, plus margin
	localparam int SEC_CYCLES = 70000;
	// stopwatch readout moves every 512 clocks at full speed
	localparam int WATCH_CYCLES = 1200;

	logic               clk;
	logic               arst_n;
	logic               stb;
	logic               we;
	rtc_pkg::rtc_addr_e addr;
	logic [31:0]        wdata;
	logic               hack;
	logic [31:0]        rdata;
	logic               irq;

	integer seed = 32'he7ce_5a99;
	int     errors = 0;
	int     checks = 0;
	int     irq_count = 0;

	rtc_clk_gen u_clk_gen (
		.o_clk    (clk),
		.o_arst_n (arst_n)
	);

	rtc_core dut (
		.i_clk       (clk),
		.i_arst_n    (arst_n),
		.i_stb       (stb),
		.i_we        (we),
		.i_addr      (addr),
		.i_data      (wdata),
		.i_hack      (hack),
		.o_data      (rdata),
		.o_interrupt (irq)
	);

	// count interrupt pulses on the falling edge, away from updates
	always @(negedge clk)
	begin
		if (arst_n && irq)
			irq_count = irq_count + 1;
	end

	////////////////////
	// model helpers
	////////////////////

	function automatic int rand_span(input int lo, input int hi);
		int r;
		r = $unsigned($random(seed)) % (hi - lo + 1);
		return lo + r;
	endfunction

	function automatic int bcd_val(input logic [7:0] b);
		return b[7:4] * 10 + b[3:0];
	endfunction

	function automatic logic [7:0] to_bcd(input int v);
		logic [7:0] r;
		r[7:4] = v / 10;
		r[3:0] = v % 10;
		return r;
	endfunction

	// seconds since midnight
	function automatic int tod_seconds(input rtc_pkg::bcd_time_t t);
		return bcd_val({2'b00, t.hours}) * 3600 + bcd_val(t.minutes) * 60 + bcd_val(t.seconds);
	endfunction

	function automatic rtc_pkg::bcd_time_t tod_from_seconds(input int s);
		rtc_pkg::bcd_time_t r;
		logic [7:0]         h;
		h         = to_bcd(s / 3600);
		r.hours   = h[5:0];
		r.minutes = to_bcd((s / 60) % 60);
		r.seconds = to_bcd(s % 60);
		return r;
	endfunction

	// one countdown step: decrement, or expire once at zero
	function automatic rtc_pkg::timer_t timer_step(input rtc_pkg::timer_t t);
		rtc_pkg::timer_t r;
		int              s;
		r = t;
		if (t.remaining == 24'h0)
		begin
			r.expired = 1'b1;
			r.running = 1'b0;
		end
		else
		begin
			s = bcd_val(t.remaining[23:16]) * 3600 + bcd_val(t.remaining[15:8]) * 60
				+ bcd_val(t.remaining[7:0]) - 1;
			r.remaining = {to_bcd(s / 3600), to_bcd((s / 60) % 60), to_bcd(s % 60)};
		end
		return r;
	endfunction

	////////////////////
	// compare tasks
	////////////////////

	task automatic time_check(input string name, input rtc_pkg::bcd_time_t exp,
		input rtc_pkg::bcd_time_t act);
		checks++;
		if (act !== exp)
		begin
			$display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic timer_check(input string name, input rtc_pkg::timer_t exp,
		input rtc_pkg::timer_t act);
		checks++;
		if (act !== exp)
		begin
			$display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic watch_check(input string name, input rtc_pkg::stopwatch_t exp,
		input rtc_pkg::stopwatch_t act);
		checks++;
		if (act !== exp)
		begin
			$display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic stamp_check(input string name, input rtc_pkg::hack_stamp_t exp,
		input rtc_pkg::hack_stamp_t act);
		checks++;
		if (act !== exp)
		begin
			$display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic word_check(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		checks++;
		if (act !== exp)
		begin
			$display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
			errors++;
		end
	endtask

	////////////////////
	// bus access
	////////////////////

	// every bus task starts and ends 1 ns after a rising edge
	task automatic bus_write(input rtc_pkg::rtc_addr_e a, input logic [31:0] d);
		stb   = 1'b1;
		we    = 1'b1;
		addr  = a;
		wdata = d;
		@(posedge clk);
		#1;
		stb = 1'b0;
		we  = 1'b0;
	endtask

	// plain address read, no strobe so nothing is consumed
	task automatic read_reg(input rtc_pkg::rtc_addr_e a, output logic [31:0] d);
		stb  = 1'b0;
		addr = a;
		@(posedge clk);
		#1;
		d = rdata;
	endtask

	// strobed read of the hack register pops the head
	task automatic pop_hack(output logic [31:0] d);
		stb  = 1'b1;
		we   = 1'b0;
		addr = rtc_pkg::RTC_ADDR_HACK;
		@(posedge clk);
		#1;
		stb = 1'b0;
		d   = rdata;
	endtask

	task automatic poll_change(input rtc_pkg::rtc_addr_e a, input logic [31:0] old,
		input int limit, output logic [31:0] d, output bit ok);
		int n;
		n  = 0;
		ok = 1'b0;
		d  = old;
		while (!ok && n < limit)
		begin
			read_reg(a, d);
			n++;
			if (d !== old)
				ok = 1'b1;
		end
		if (!ok)
		begin
			$display("timeout: register %0d did not change within %0d cycles", a, limit);
			errors++;
		end
	endtask

	task automatic wait_irq(input int base, input int limit, output bit ok);
		int n;
		n = 0;
		while (irq_count == base && n < limit)
		begin
			@(posedge clk);
			#1;
			n++;
		end
		ok = (irq_count != base);
		if (!ok)
		begin
			$display("timeout: no interrupt within %0d cycles", limit);
			errors++;
		end
	endtask

	task automatic end_of_test(input string name, input int e0);
		$display("test %-10s done, %0d errors", name, errors - e0);
	endtask

	////////////////////
	// tests
	////////////////////

	task automatic readback_test();
		int                 e0;
		logic [31:0]        v;
		logic [31:0]        d;
		logic [7:0]         h;
		rtc_pkg::bcd_time_t f;
		rtc_pkg::bcd_time_t al;
		e0 = errors;
		for (int i = 0; i < 4; i++)
		begin
			v = $random(seed);
			bus_write(rtc_pkg::RTC_ADDR_SPEED, v);
			read_reg(rtc_pkg::RTC_ADDR_SPEED, d);
			word_check("speed", v, d);
		end
		// alarm stays disabled here, so tripped and enabled read zero
		al = '0;
		for (int i = 0; i < 6; i++)
		begin
			h = to_bcd(rand_span(0, 23));
			f = {h[5:0], to_bcd(rand_span(0, 59)), to_bcd(rand_span(0, 59))};
			// roughly one field in three is masked with all ones
			if (rand_span(0, 2) == 0)
				f.hours = 6'h3f;
			else
				al.hours = f.hours;
			if (rand_span(0, 2) == 0)
				f.minutes = 8'hff;
			else
				al.minutes = f.minutes;
			if (rand_span(0, 2) == 0)
				f.seconds = 8'hff;
			else
				al.seconds = f.seconds;
			bus_write(rtc_pkg::RTC_ADDR_ALARM, {10'h0, f});
			read_reg(rtc_pkg::RTC_ADDR_ALARM, d);
			word_check("alarm", {10'h0, al}, d);
		end
		// fastest the 32 bit speed register allows, a carry per 256 clocks
		bus_write(rtc_pkg::RTC_ADDR_SPEED, 32'hffff_ffff);
		read_reg(rtc_pkg::RTC_ADDR_SPEED, d);
		word_check("speed", 32'hffff_ffff, d);
		end_of_test("readback", e0);
	endtask

	task automatic rollover_case(input rtc_pkg::bcd_time_t start, input int steps);
		logic [31:0]        d;
		logic [31:0]        nd;
		rtc_pkg::bcd_time_t exp;
		bit                 ok;
		bus_write(rtc_pkg::RTC_ADDR_CLOCK, {10'h0, start});
		read_reg(rtc_pkg::RTC_ADDR_CLOCK, d);
		time_check("clock", start, d[21:0]);
		for (int i = 0; i < steps; i++)
		begin
			poll_change(rtc_pkg::RTC_ADDR_CLOCK, d, SEC_CYCLES, nd, ok);
			if (!ok)
				break;
			exp = tod_from_seconds((tod_seconds(d[21:0]) + 1) % 86400);
			time_check("clock", exp, nd[21:0]);
			d = nd;
		end
	endtask

	task automatic rollover_test();
		int e0;
		e0 = errors;
		rollover_case(tod_from_seconds(rand_span(0, 86399)), 1);
		// midnight wrap through every field
		rollover_case(22'h23_59_58, 2);
		end_of_test("rollover", e0);
	endtask

	task automatic countdown_test();
		int              e0;
		int              irq0;
		int              steps;
		logic [23:0]     start;
		logic [31:0]     d;
		logic [31:0]     nd;
		rtc_pkg::timer_t cur;
		bit              ok;
		e0    = errors;
		start = {16'h0, to_bcd(rand_span(1, 2))};
		irq0  = irq_count;
		bus_write(rtc_pkg::RTC_ADDR_TIMER, {7'h0, 1'b1, start});
		read_reg(rtc_pkg::RTC_ADDR_TIMER, d);
		timer_check("timer", {1'b0, 1'b1, start}, d[25:0]);
		cur   = d[25:0];
		steps = 0;
		ok    = 1'b1;
		while (ok && !cur.expired && steps < 8)
		begin
			poll_change(rtc_pkg::RTC_ADDR_TIMER, d, SEC_CYCLES, nd, ok);
			if (ok)
			begin
				timer_check("timer", timer_step(cur), nd[25:0]);
				cur = nd[25:0];
				d   = nd;
			end
			steps++;
		end
		if (!cur.expired)
		begin
			$display("countdown never reached the expired state");
			errors++;
		end
		word_check("interrupt count", irq0 + 1, irq_count);
		// zero write on zero remaining restores the start value
		bus_write(rtc_pkg::RTC_ADDR_TIMER, 32'h0);
		read_reg(rtc_pkg::RTC_ADDR_TIMER, d);
		timer_check("timer", {1'b0, 1'b0, start}, d[25:0]);
		end_of_test("countdown", e0);
	endtask

	task automatic stopwatch_test();
		int          e0;
		logic [31:0] d;
		logic [31:0] nd;
		logic [31:0] held;
		bit          ok;
		e0 = errors;
		bus_write(rtc_pkg::RTC_ADDR_STOPWATCH, 32'h1);
		read_reg(rtc_pkg::RTC_ADDR_STOPWATCH, d);
		word_check("stopwatch.running", 32'h1, d[0]);
		for (int i = 0; i < 6; i++)
		begin
			poll_change(rtc_pkg::RTC_ADDR_STOPWATCH, d, WATCH_CYCLES, nd, ok);
			if (!ok)
				break;
			if (nd[31:1] <= d[31:1])
			begin
				$display("stopwatch moved from %h to %h instead of counting up", d, nd);
				errors++;
			end
			d = nd;
		end
		// stopped value must hold
		bus_write(rtc_pkg::RTC_ADDR_STOPWATCH, 32'h0);
		read_reg(rtc_pkg::RTC_ADDR_STOPWATCH, d);
		word_check("stopwatch.running", 32'h0, d[0]);
		repeat (WATCH_CYCLES) @(posedge clk);
		#1;
		read_reg(rtc_pkg::RTC_ADDR_STOPWATCH, held);
		watch_check("stopwatch", d, held);
		// 3 while stopped clears and restarts
		bus_write(rtc_pkg::RTC_ADDR_STOPWATCH, 32'h3);
		read_reg(rtc_pkg::RTC_ADDR_STOPWATCH, d);
		watch_check("stopwatch", 32'h1, d);
		poll_change(rtc_pkg::RTC_ADDR_STOPWATCH, d, WATCH_CYCLES, nd, ok);
		// 3 while running leaves the count alone
		bus_write(rtc_pkg::RTC_ADDR_STOPWATCH, 32'h3);
		read_reg(rtc_pkg::RTC_ADDR_STOPWATCH, d);
		if (d[31:1] < nd[31:1] || !d[0])
		begin
			$display("stopwatch was cleared or stopped by a write of 3 while running");
			errors++;
		end
		// 2 clears whether running or not
		bus_write(rtc_pkg::RTC_ADDR_STOPWATCH, 32'h2);
		read_reg(rtc_pkg::RTC_ADDR_STOPWATCH, d);
		watch_check("stopwatch", 32'h0, d);
		// run and stop again so the stopped count is nonzero
		bus_write(rtc_pkg::RTC_ADDR_STOPWATCH, 32'h1);
		read_reg(rtc_pkg::RTC_ADDR_STOPWATCH, d);
		poll_change(rtc_pkg::RTC_ADDR_STOPWATCH, d, WATCH_CYCLES, nd, ok);
		bus_write(rtc_pkg::RTC_ADDR_STOPWATCH, 32'h0);
		read_reg(rtc_pkg::RTC_ADDR_STOPWATCH, d);
		if (d[31:1] == 31'h0)
		begin
			$display("stopwatch did not count before the stopped clear");
			errors++;
		end
		bus_write(rtc_pkg::RTC_ADDR_STOPWATCH, 32'h2);
		read_reg(rtc_pkg::RTC_ADDR_STOPWATCH, d);
		watch_check("stopwatch", 32'h0, d);
		end_of_test("stopwatch", e0);
	endtask

	task automatic alarm_test();
		int                 e0;
		int                 irq0;
		int                 delta;
		logic [31:0]        d;
		logic [31:0]        nd;
		rtc_pkg::bcd_time_t al;
		bit                 ok;
		e0 = errors;
		// sync to a fresh second so the alarm is written well before the next tick
		read_reg(rtc_pkg::RTC_ADDR_CLOCK, d);
		poll_change(rtc_pkg::RTC_ADDR_CLOCK, d, SEC_CYCLES, nd, ok);
		delta = rand_span(1, 3);
		al    = tod_from_seconds((tod_seconds(nd[21:0]) + delta) % 86400);
		irq0  = irq_count;
		bus_write(rtc_pkg::RTC_ADDR_ALARM, {6'h0, 2'b11, 2'b00, al});
		wait_irq(irq0, (delta + 1) * SEC_CYCLES, ok);
		read_reg(rtc_pkg::RTC_ADDR_CLOCK, d);
		time_check("clock", al, d[21:0]);
		read_reg(rtc_pkg::RTC_ADDR_ALARM, d);
		word_check("alarm", {6'h0, 2'b11, 2'b00, al}, d);
		// acknowledge with every field masked
		bus_write(rtc_pkg::RTC_ADDR_ALARM, 32'h033f_ffff);
		read_reg(rtc_pkg::RTC_ADDR_ALARM, d);
		word_check("alarm", {6'h0, 2'b01, 2'b00, al}, d);
		bus_write(rtc_pkg::RTC_ADDR_ALARM, 32'h003f_ffff);
		end_of_test("alarm", e0);
	endtask

	task automatic hack_test();
		int          e0;
		int          pulses;
		int          valid_cnt;
		int          expect_cnt;
		bit          done;
		logic [29:0] prev;
		logic [31:0] d;
		e0     = errors;
		pulses = rand_span(1, 6);
		for (int i = 0; i < pulses; i++)
		begin
			hack = 1'b1;
			@(posedge clk);
			#1;
			hack = 1'b0;
			// random gap so some stamps differ in sub-second count
			repeat (rand_span(1, 300)) @(posedge clk);
			#1;
		end
		prev      = '0;
		valid_cnt = 0;
		done      = 1'b0;
		for (int r = 0; r < 8 && !done; r++)
		begin
			pop_hack(d);
			if (r == 0)
				word_check("hack.overflow", (pulses > `RTC_HACK_DEPTH), d[30]);
			if (d[31])
			begin
				valid_cnt++;
				if (d[29:0] < prev)
				begin
					$display("hack stamp %h is older than the one before it, %h", d[29:0], prev);
					errors++;
				end
				prev = d[29:0];
			end
			else
			begin
				done = 1'b1;
				stamp_check("hack.stamp", '0, d[29:0]);
			end
		end
		if (!done)
		begin
			$display("hack FIFO still reported valid data after 8 reads");
			errors++;
		end
		expect_cnt = (pulses < `RTC_HACK_DEPTH) ? pulses : `RTC_HACK_DEPTH;
		word_check("hack.count", expect_cnt, valid_cnt);
		end_of_test("hack", e0);
	endtask

	////////////////////
	// main sequence
	////////////////////

	initial
	begin
		int n;
		stb   = 1'b0;
		we    = 1'b0;
		addr  = rtc_pkg::RTC_ADDR_CLOCK;
		wdata = '0;
		hack  = 1'b0;
		n     = 0;
		while (arst_n !== 1'b1 && n < 20)
		begin
			@(posedge clk);
			n++;
		end
		if (arst_n !== 1'b1)
		begin
			$display("reset was never released");
			errors++;
		end
		@(posedge clk);
		#1;
		readback_test();
		rollover_test();
		countdown_test();
		stopwatch_test();
		alarm_test();
		hack_test();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+source
source/rtc_pkg.sv
source/rtc_tick_gen.sv
source/rtc_time_of_day.sv
source/rtc_countdown.sv
source/rtc_stopwatch.sv
source/rtc_hack_fifo.sv
source/rtc_core.sv
dv/rtc_clk_gen.sv
dv/rtc_tb.sv

// ==== Bender.yml ====
package:
  name: rtc_subsystem

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/rtc_pkg.sv
      - source/rtc_tick_gen.sv
      - source/rtc_time_of_day.sv
      - source/rtc_countdown.sv
      - source/rtc_stopwatch.sv
      - source/rtc_hack_fifo.sv
      - source/rtc_core.sv
  - target: test
    include_dirs:
      - source
    files:
      - dv/rtc_clk_gen.sv
      - dv/rtc_tb.sv
